/* dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Cache geometry
`define DC_SETS 16
`define DC_WORDS 4

// Address field widths for a 32-bit byte address
`define DC_INDEX_BITS 4
`define DC_OFFSET_BITS 2
`define DC_TAG_BITS 24

// Tag + index + word offset + 2 byte-select bits must add up to 32
// 24 + 4 + 2 + 2

`endif

/* dcachePkg.sv */
`default_nettype none

`include "dcache_consts.svh"

package dcachePkg;

  // One address word, seen flat or split into its cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [`DC_TAG_BITS-1:0]    tag;
      logic [`DC_INDEX_BITS-1:0]  index;
      logic [`DC_OFFSET_BITS-1:0] word;
      logic [1:0]                 byteSel;
    } f;
  } cacheAddrT;

  // Controller sequencing
  typedef enum logic [2:0] {
    lookup,
    writeBack,
    refill,
    flushScan,
    flushWrite
  } ctrlStateT;

endpackage

`default_nettype wire

/* tagIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

interface tagIf;
  // Controller side
  logic [`DC_INDEX_BITS-1:0] index;
  logic [`DC_TAG_BITS-1:0]   lookupTag;
  logic [`DC_TAG_BITS-1:0]   writeTag;
  logic                      fillWay;
  logic                      fillEn;
  logic                      setDirtyEn;
  logic                      clearDirtyEn;
  logic                      touchEn;
  logic                      touchWay;

  // Tag store side
  logic                      hit;
  logic                      hitWay;
  logic                      victimWay;
  logic                      victimValid;
  logic                      victimDirty;
  logic [`DC_TAG_BITS-1:0]   victimTag;

  modport ctrl (
    output index, lookupTag, writeTag, fillWay, fillEn, setDirtyEn, clearDirtyEn,
    output touchEn, touchWay,
    input  hit, hitWay, victimWay, victimValid, victimDirty, victimTag
  );

  modport store (
    input  index, lookupTag, writeTag, fillWay, fillEn, setDirtyEn, clearDirtyEn,
    input  touchEn, touchWay,
    output hit, hitWay, victimWay, victimValid, victimDirty, victimTag
  );
endinterface

`default_nettype wire

/* tagStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module tagStore (
  input logic clk,
  input logic reset,
  tagIf.store tags
);
  logic [1:0][`DC_SETS-1:0]    validArr;
  logic [1:0][`DC_SETS-1:0]    dirtyArr;
  // Per set, the way to replace next
  logic [`DC_SETS-1:0]         lruArr;
  logic [`DC_TAG_BITS-1:0]     tagArr [2][`DC_SETS];
  logic                        hit0;
  logic                        hit1;
  logic                        valid0;
  logic                        valid1;

  assign valid0 = validArr[0][tags.index];
  assign valid1 = validArr[1][tags.index];

  // Hit compare on both ways
  assign hit0 = valid0 && (tagArr[0][tags.index] == tags.lookupTag);
  assign hit1 = valid1 && (tagArr[1][tags.index] == tags.lookupTag);

  assign tags.hit    = hit0 || hit1;
  assign tags.hitWay = hit1;

  // Empty way first, otherwise LRU
  always_comb begin
    if (!valid0) begin
      tags.victimWay = 1'b0;
    end else if (!valid1) begin
      tags.victimWay = 1'b1;
    end else begin
      tags.victimWay = lruArr[tags.index];
    end
  end

  // Describes whichever way the controller points at
  assign tags.victimValid = validArr[tags.fillWay][tags.index];
  assign tags.victimDirty = dirtyArr[tags.fillWay][tags.index];
  assign tags.victimTag   = tagArr[tags.fillWay][tags.index];

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validArr <= '0;
      dirtyArr <= '0;
      lruArr   <= '0;
    end else begin
      if (tags.fillEn) begin
        validArr[tags.fillWay][tags.index] <= 1'b1;
        dirtyArr[tags.fillWay][tags.index] <= 1'b0;
      end
      if (tags.clearDirtyEn) begin
        dirtyArr[tags.fillWay][tags.index] <= 1'b0;
      end
      if (tags.setDirtyEn) begin
        dirtyArr[tags.touchWay][tags.index] <= 1'b1;
      end
      // Other way becomes LRU
      if (tags.touchEn) begin
        lruArr[tags.index] <= ~tags.touchWay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tags.fillEn) begin
      tagArr[tags.fillWay][tags.index] <= tags.writeTag;
    end
  end
endmodule

`default_nettype wire

/* dataStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dataStore (
  input  logic                       clk,
  input  logic [`DC_INDEX_BITS-1:0]  index,
  input  logic                       way,
  input  logic [`DC_OFFSET_BITS-1:0] word,
  input  logic                       wrEn,
  input  logic                       fillSel,
  input  logic [3:0]                 wrMask,
  input  logic [31:0]                cpuData,
  input  logic [31:0]                fillData,
  output logic [31:0]                rdData
);
  logic [31:0] lineMem [2][`DC_SETS][`DC_WORDS];
  logic [31:0] wrData;
  logic [3:0]  laneEn;

  // Fill beats always replace the whole word
  assign wrData = fillSel ? fillData : cpuData;
  assign laneEn = fillSel ? 4'hF : wrMask;

  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int b = 0; b < 4; b++) begin
        if (laneEn[b]) begin
          lineMem[way][index][word][b*8 +: 8] <= wrData[b*8 +: 8];
        end
      end
    end
  end

  // Combinational read that also feeds writeback data
  assign rdData = lineMem[way][index][word];
endmodule

`default_nettype wire

/* busPort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module busPort (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       burstStart,
  input  logic                       burstWrite,
  input  logic [`DC_TAG_BITS-1:0]    lineTag,
  input  logic [`DC_INDEX_BITS-1:0]  lineIndex,
  input  logic                       memReady,
  output logic                       memValid,
  output logic                       memWrite,
  output logic [31:0]                memAddr,
  output logic                       beatDone,
  output logic                       burstDone,
  output logic [`DC_OFFSET_BITS-1:0] beatWord
);
  import dcachePkg::*;

  logic [`DC_OFFSET_BITS-1:0] beatCnt;
  logic [`DC_TAG_BITS-1:0]    tagQ;
  logic [`DC_INDEX_BITS-1:0]  indexQ;
  cacheAddrT                  beatAddr;

  // Word-aligned beat address
  always_comb begin
    beatAddr.f.tag     = tagQ;
    beatAddr.f.index   = indexQ;
    beatAddr.f.word    = beatCnt;
    beatAddr.f.byteSel = 2'b00;
  end

  assign memAddr   = beatAddr.raw;
  assign beatWord  = beatCnt;
  assign beatDone  = memValid && memReady;
  assign burstDone = beatDone && (beatCnt == `DC_OFFSET_BITS'(`DC_WORDS - 1));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      memValid <= 1'b0;
      memWrite <= 1'b0;
      beatCnt  <= '0;
    end else if (burstStart) begin
      memValid <= 1'b1;
      memWrite <= burstWrite;
      beatCnt  <= '0;
    end else if (beatDone) begin
      // Held through stalls, dropped after the last beat
      memValid <= !burstDone;
      beatCnt  <= beatCnt + 1'b1;
    end
  end

  // Line address latched for the whole burst
  always_ff @(posedge clk) begin
    if (burstStart) begin
      tagQ   <= lineTag;
      indexQ <= lineIndex;
    end
  end
endmodule

`default_nettype wire

/* cacheController.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module cacheController (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       reqValid,
  input  logic                       reqWrite,
  input  dcachePkg::cacheAddrT       reqAddr,
  input  logic [3:0]                 reqMask,
  input  logic                       flushValid,
  output logic                       reqReady,
  output logic                       rspValid,
  output logic [31:0]                rspData,
  output logic                       flushReady,
  tagIf.ctrl                         tags,
  output logic                       burstStart,
  output logic                       burstWrite,
  output logic [`DC_TAG_BITS-1:0]    lineTag,
  output logic [`DC_INDEX_BITS-1:0]  lineIndex,
  input  logic                       beatDone,
  input  logic [`DC_OFFSET_BITS-1:0] beatWord,
  input  logic                       burstDone,
  output logic [`DC_INDEX_BITS-1:0]  dataIndex,
  output logic                       dataWay,
  output logic [`DC_OFFSET_BITS-1:0] dataWord,
  output logic                       wrEn,
  output logic                       fillSel,
  output logic [3:0]                 wrMask,
  input  logic [31:0]                rdData
);
  import dcachePkg::*;

  ctrlStateT state, nextState;

  // Flush walk, set in the upper bits and way in bit 0
  logic [`DC_INDEX_BITS:0]   scanCnt;
  logic                      scanInc;
  logic                      missWay;
  logic                      refillKick;
  logic [`DC_INDEX_BITS-1:0] curIndex;
  logic                      curWay;

  // Set/way under work in each state
  always_comb begin
    curIndex = reqAddr.f.index;
    curWay   = missWay;
    dataWord = beatWord;
    case (state)
      lookup: begin
        curWay   = tags.victimWay;
        dataWord = reqAddr.f.word;
      end
      flushScan, flushWrite: begin
        curIndex = scanCnt[`DC_INDEX_BITS:1];
        curWay   = scanCnt[0];
      end
      default: ;
    endcase
  end

  assign tags.index     = curIndex;
  assign tags.fillWay   = curWay;
  assign tags.lookupTag = reqAddr.f.tag;
  assign tags.writeTag  = reqAddr.f.tag;
  assign tags.touchWay  = tags.hitWay;
  assign lineIndex      = curIndex;
  assign dataIndex      = curIndex;
  assign dataWay        = (state == lookup) ? tags.hitWay : curWay;
  assign wrMask         = reqMask;

  always_comb begin
    nextState         = state;
    reqReady          = 1'b0;
    flushReady        = 1'b0;
    burstStart        = 1'b0;
    burstWrite        = 1'b0;
    lineTag           = reqAddr.f.tag;
    wrEn              = 1'b0;
    fillSel           = 1'b0;
    scanInc           = 1'b0;
    tags.fillEn       = 1'b0;
    tags.setDirtyEn   = 1'b0;
    tags.clearDirtyEn = 1'b0;
    tags.touchEn      = 1'b0;
    case (state)
      lookup: begin
        if (flushValid) begin
          nextState = flushScan;
        end else if (reqValid && tags.hit) begin
          reqReady        = 1'b1;
          wrEn            = reqWrite;
          tags.setDirtyEn = reqWrite;
          tags.touchEn    = 1'b1;
        end else if (reqValid) begin
          burstStart = 1'b1;
          if (tags.victimValid && tags.victimDirty) begin
            burstWrite = 1'b1;
            lineTag    = tags.victimTag;
            nextState  = writeBack;
          end else begin
            nextState = refill;
          end
        end
      end
      writeBack: begin
        if (burstDone) begin
          nextState = refill;
        end
      end
      refill: begin
        // Refill burst starts one cycle after a writeback ends
        burstStart = refillKick;
        wrEn       = beatDone;
        fillSel    = 1'b1;
        if (burstDone) begin
          tags.fillEn = 1'b1;
          nextState   = lookup;
        end
      end
      flushScan: begin
        if (tags.victimValid && tags.victimDirty) begin
          burstStart = 1'b1;
          burstWrite = 1'b1;
          lineTag    = tags.victimTag;
          nextState  = flushWrite;
        end else if (&scanCnt) begin
          flushReady = 1'b1;
          nextState  = lookup;
        end else begin
          scanInc = 1'b1;
        end
      end
      flushWrite: begin
        // Same way is rescanned, clean this time
        if (burstDone) begin
          tags.clearDirtyEn = 1'b1;
          nextState         = flushScan;
        end
      end
      default: nextState = lookup;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state      <= lookup;
      scanCnt    <= '0;
      refillKick <= 1'b0;
      rspValid   <= 1'b0;
    end else begin
      state      <= nextState;
      refillKick <= (state == writeBack) && burstDone;
      rspValid   <= reqReady && !reqWrite;
      if (state == lookup) begin
        scanCnt <= '0;
      end else if (scanInc) begin
        scanCnt <= scanCnt + 1'b1;
      end
    end
  end

  // Victim way and read response
  always_ff @(posedge clk) begin
    if (state == lookup && reqValid && !tags.hit && !flushValid) begin
      missWay <= tags.victimWay;
    end
    if (reqReady && !reqWrite) begin
      rspData <= rdData;
    end
  end
endmodule

`default_nettype wire

/* dataCache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dataCache (
  input  logic        clk,
  input  logic        reset,
  input  logic        reqValid,
  output logic        reqReady,
  input  logic        reqWrite,
  input  logic [31:0] reqAddr,
  input  logic [31:0] reqWData,
  input  logic [3:0]  reqMask,
  output logic        rspValid,
  output logic [31:0] rspData,
  input  logic        flushValid,
  output logic        flushReady,
  output logic        memValid,
  input  logic        memReady,
  output logic        memWrite,
  output logic [31:0] memAddr,
  output logic [31:0] memWData,
  input  logic [31:0] memRData
);
  tagIf tags ();

  logic                       burstStart;
  logic                       burstWrite;
  logic [`DC_TAG_BITS-1:0]    lineTag;
  logic [`DC_INDEX_BITS-1:0]  lineIndex;
  logic                       beatDone;
  logic                       burstDone;
  logic [`DC_OFFSET_BITS-1:0] beatWord;
  logic [`DC_INDEX_BITS-1:0]  dataIndex;
  logic                       dataWay;
  logic [`DC_OFFSET_BITS-1:0] dataWord;
  logic                       wrEn;
  logic                       fillSel;
  logic [3:0]                 wrMask;
  logic [31:0]                rdData;

  cacheController ctrl0 (
    .clk, .reset, .reqValid, .reqWrite, .reqAddr, .reqMask, .flushValid,
    .reqReady, .rspValid, .rspData, .flushReady, .tags(tags.ctrl),
    .burstStart, .burstWrite, .lineTag, .lineIndex, .beatDone, .beatWord, .burstDone,
    .dataIndex, .dataWay, .dataWord, .wrEn, .fillSel, .wrMask, .rdData
  );

  tagStore tags0 (.clk, .reset, .tags(tags.store));

  // Read beats land straight in the data array
  dataStore data0 (
    .clk, .index(dataIndex), .way(dataWay), .word(dataWord), .wrEn, .fillSel, .wrMask,
    .cpuData(reqWData), .fillData(memRData), .rdData
  );

  busPort bus0 (
    .clk, .reset, .burstStart, .burstWrite, .lineTag, .lineIndex, .memReady,
    .memValid, .memWrite, .memAddr, .beatDone, .burstDone, .beatWord
  );

  // Writeback data comes from the word the beat counter selects
  assign memWData = rdData;
endmodule

`default_nettype wire

/* dataCache_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module dataCacheProperties (
  input logic        clk,
  input logic        reset,
  input logic        reqValid,
  input logic        reqReady,
  input logic        reqWrite,
  input logic        rspValid,
  input logic        memValid,
  input logic        memReady,
  input logic        memWrite,
  input logic [31:0] memAddr
);
  // A stalled beat keeps its request unchanged
  assert property (@(posedge clk) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memWrite))
    else $error("memory beat changed before memReady");

  // Response only after an accepted read
  assert property (@(posedge clk) disable iff (reset)
    rspValid |-> $past(reqValid && reqReady && !reqWrite))
    else $error("rspValid without an accepted read");

  // No hit is served while a burst runs
  assert property (@(posedge clk) disable iff (reset) !(reqReady && memValid))
    else $error("reqReady high during a memory burst");
endmodule

`default_nettype wire

/* dataCacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dataCacheTb;
  localparam int MEM_WORDS = `DC_SETS * `DC_WORDS * 4;
  localparam int WAIT_LIMIT = 200;
  localparam logic [1:0] OP_READ = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_FLUSH = 2'd2;

  // With useRef set the expected read value comes from refMem
  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [3:0]  expRd;
    logic [3:0]  expWr;
    logic [31:0] wbAddr;
    logic        useRef;
    logic [31:0] expData;
  } rowT;

  logic        clk = 1'b0;
  logic        reset;
  logic        reqValid;
  logic        reqReady;
  logic        reqWrite;
  logic [31:0] reqAddr;
  logic [31:0] reqWData;
  logic [3:0]  reqMask;
  logic        rspValid;
  logic [31:0] rspData;
  logic        flushValid;
  logic        flushReady;
  logic        memValid;
  logic        memReady;
  logic        memWrite;
  logic [31:0] memAddr;
  logic [31:0] memWData;
  logic [31:0] memRData;

  logic [31:0] memArr [MEM_WORDS];
  logic [31:0] refMem [MEM_WORDS];
  logic [31:0] rdLog [$];
  logic [31:0] wrLog [$];
  rowT         rows [$];

  dataCache dut0 (
    .clk, .reset, .reqValid, .reqReady, .reqWrite, .reqAddr, .reqWData, .reqMask,
    .rspValid, .rspData, .flushValid, .flushReady, .memValid, .memReady, .memWrite,
    .memAddr, .memWData, .memRData
  );

  bind dataCache dataCacheProperties props0 (
    .clk(clk), .reset(reset), .reqValid(reqValid), .reqReady(reqReady),
    .reqWrite(reqWrite), .rspValid(rspValid), .memValid(memValid),
    .memReady(memReady), .memWrite(memWrite), .memAddr(memAddr)
  );

  always #5 clk = ~clk;

  // Initial memory word at index w
  function automatic logic [31:0] patternAt(input int w);
    return 32'h5A00_0000 ^ (w << 18) ^ (w << 2);
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("CHECK FAILED at %0t ns: %s got %08h expected %08h",
                        $time, what, got, exp));
    end
  endtask

  task automatic afterEdge();
    @(posedge clk);
    #1;
  endtask

  // Returns at the negedge where the handshake signal is seen high
  task automatic waitAccept(input logic isFlush);
    int n;
    n = 0;
    @(negedge clk);
    while (!(isFlush ? flushReady : reqReady) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(isFlush ? flushReady : reqReady)) begin
      failRun(isFlush ? "Timeout: flush never completed" : "Timeout: request never accepted");
    end
  endtask

  task automatic waitRsp(output int lat);
    lat = 0;
    @(negedge clk);
    while (!rspValid && lat < WAIT_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    if (!rspValid) begin
      failRun("Timeout: read response never arrived");
    end
  endtask

  task automatic mergeRef(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        refMem[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic compareWords(input int first, input int count, input int num);
    for (int i = first; i < first + count; i++) begin
      checkEq(memArr[i], refMem[i], $sformatf("row %0d memory word %0d", num, i));
    end
  endtask

  task automatic addRow(input logic [1:0] op, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] mask, input int expRd, input int expWr,
                        input logic [31:0] wbAddr, input logic useRef,
                        input logic [31:0] expData);
    rows.push_back('{op, addr, data, mask, 4'(expRd), 4'(expWr), wbAddr, useRef, expData});
  endtask

  task automatic applyRow(input rowT r, input int num);
    int lat;
    afterEdge();
    rdLog.delete();
    wrLog.delete();
    if (r.op == OP_FLUSH) begin
      flushValid = 1'b1;
      waitAccept(1'b1);
      afterEdge();
      flushValid = 1'b0;
      checkEq(flushReady, 1'b0, $sformatf("row %0d flushReady pulse width", num));
    end else begin
      reqValid = 1'b1;
      reqWrite = (r.op == OP_WRITE);
      reqAddr  = r.addr;
      reqWData = r.data;
      reqMask  = r.mask;
      waitAccept(1'b0);
      afterEdge();
      reqValid = 1'b0;
      if (r.op == OP_WRITE) begin
        mergeRef(r.addr, r.data, r.mask);
      end else begin
        waitRsp(lat);
        checkEq(lat, 0, $sformatf("row %0d response latency", num));
        checkEq(rspData, r.useRef ? refMem[r.addr[9:2]] : r.expData,
                $sformatf("row %0d read data", num));
      end
    end
    checkEq(rdLog.size(), r.expRd, $sformatf("row %0d read beats", num));
    checkEq(wrLog.size(), r.expWr, $sformatf("row %0d write beats", num));
    // Refill walks the requested line in order
    foreach (rdLog[k]) begin
      checkEq(rdLog[k], {r.addr[31:4], 4'h0} + 32'(k * 4),
              $sformatf("row %0d refill address", num));
    end
    if (r.op == OP_FLUSH) begin
      compareWords(0, MEM_WORDS, num);
    end else if (wrLog.size() != 0) begin
      foreach (wrLog[k]) begin
        checkEq(wrLog[k], r.wbAddr + 32'(k * 4), $sformatf("row %0d writeback address", num));
      end
      compareWords(int'(r.wbAddr[9:2]), `DC_WORDS, num);
    end
  endtask

  // Memory model with a random 0 to 3 cycle stall per beat
  initial begin : memModel
    int   stallLeft;
    logic armed;
    memReady  = 1'b0;
    memRData  = '0;
    stallLeft = 0;
    armed     = 1'b0;
    void'($urandom(32'h216));
    for (int i = 0; i < MEM_WORDS; i++) begin
      memArr[i] = patternAt(i);
    end
    forever begin
      @(posedge clk);
      if (!reset && memValid && memReady) begin
        if (memAddr[31:10] != '0) begin
          failRun($sformatf("Memory access outside the model at %08h", memAddr));
        end else if (memWrite) begin
          memArr[memAddr[9:2]] = memWData;
          wrLog.push_back(memAddr);
        end else begin
          rdLog.push_back(memAddr);
        end
      end
      #1;
      memReady = 1'b0;
      if (!reset && memValid) begin
        if (!armed) begin
          stallLeft = int'($urandom % 4);
          armed     = 1'b1;
        end
        if (stallLeft == 0) begin
          memReady = 1'b1;
          memRData = memArr[memAddr[9:2]];
          armed    = 1'b0;
        end else begin
          stallLeft--;
        end
      end
    end
  end

  initial begin
    reset      = 1'b1;
    reqValid   = 1'b0;
    reqWrite   = 1'b0;
    reqAddr    = '0;
    reqWData   = '0;
    reqMask    = '0;
    flushValid = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      refMem[i] = patternAt(i);
    end
    // Set 0 miss then hits and masked writes
    addRow(OP_READ, 32'h004, 0, 0, 4, 0, 0, 1'b0, patternAt(1));
    addRow(OP_READ, 32'h004, 0, 0, 0, 0, 0, 1'b0, patternAt(1));
    addRow(OP_READ, 32'h008, 0, 0, 0, 0, 0, 1'b1, 0);
    addRow(OP_WRITE, 32'h004, 32'h1122_3344, 4'b0101, 0, 0, 0, 1'b0, 0);
    addRow(OP_READ, 32'h004, 0, 0, 0, 0, 0, 1'b1, 0);
    addRow(OP_WRITE, 32'h00C, 32'hDEAD_BEEF, 4'b1000, 0, 0, 0, 1'b0, 0);
    addRow(OP_READ, 32'h00C, 0, 0, 0, 0, 0, 1'b1, 0);
    // LRU in set 2 where C evicts B
    addRow(OP_READ, 32'h020, 0, 0, 4, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h120, 0, 0, 4, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h024, 0, 0, 0, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h220, 0, 0, 4, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h028, 0, 0, 0, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h124, 0, 0, 4, 0, 0, 1'b1, 0);
    // Dirty line 0x000 written back before the refill
    addRow(OP_READ, 32'h100, 0, 0, 4, 0, 0, 1'b1, 0);
    addRow(OP_WRITE, 32'h104, 32'hCAFE_F00D, 4'b1111, 0, 0, 0, 1'b0, 0);
    addRow(OP_READ, 32'h200, 0, 0, 4, 4, 32'h000, 1'b1, 0);
    addRow(OP_WRITE, 32'h030, 32'h0BAD_C0DE, 4'b1111, 4, 0, 0, 1'b0, 0);
    addRow(OP_WRITE, 32'h034, 32'h0000_A55A, 4'b0011, 0, 0, 0, 1'b0, 0);
    // Flush of two dirty lines then a flush that finds none
    addRow(OP_FLUSH, 0, 0, 0, 0, 8, 0, 1'b0, 0);
    addRow(OP_FLUSH, 0, 0, 0, 0, 0, 0, 1'b0, 0);
    addRow(OP_READ, 32'h104, 0, 0, 0, 0, 0, 1'b1, 0);
    addRow(OP_READ, 32'h034, 0, 0, 0, 0, 0, 1'b1, 0);

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    checkEq(rspValid, 1'b0, "rspValid after reset");
    checkEq(memValid, 1'b0, "memValid after reset");
    checkEq(flushReady, 1'b0, "flushReady after reset");
    foreach (rows[i]) begin
      applyRow(rows[i], i);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end
endmodule

`default_nettype wire

/* build.f */
+incdir+.
dcachePkg.sv
tagIf.sv
tagStore.sv
dataStore.sv
busPort.sv
cacheController.sv
dataCache.sv
dataCache_properties.sv
dataCacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module dataCacheTb -f build.f -o dataCacheSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/dataCacheSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation completed"
exit 0
